// File: logic/block_pkg.sv
`default_nettype none

package block_pkg;

	// ------------------------------------------------------------------------
	// block store geometry
	// ------------------------------------------------------------------------
	localparam int N_BLOCKS   = 256;
	localparam int GAIN_SHIFT = 8;      // q8.8 gain

	typedef logic [7:0]  block_addr_t;  // block number or active count
	typedef logic [15:0] data_t;        // sample, gain, offset, result
	typedef logic [31:0] word_t;        // {offset, gain}
	typedef logic [33:0] acc_t;         // unsaturated sum

endpackage

`default_nettype wire

// File: logic/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	localparam int CMD_OP_W = 2;

	typedef enum logic [CMD_OP_W - 1 : 0] {
		OP_SET_GAIN   = 2'd0,  // low half
		OP_SET_OFFSET = 2'd1,  // high half
		OP_SET_ACTIVE = 2'd2,
		OP_SYNC       = 2'd3
	} cmd_op_t;

endpackage

`default_nettype wire

// File: logic/cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decode (
	input  wire logic                   clk,
	input  wire logic                   reset,

	input  wire logic                   cmd_valid,
	input  wire cmd_pkg::cmd_op_t       cmd_op,
	input  wire block_pkg::block_addr_t cmd_addr,
	input  wire block_pkg::data_t       cmd_data,

	input  wire logic                   syncing,

	output logic                        write_enable,
	output logic                        write_select,
	output block_pkg::block_addr_t      write_addr,
	output block_pkg::data_t            write_value,

	output logic                        sync,
	output block_pkg::block_addr_t      n_active_blocks,
	output logic                        sync_done
);

	logic syncing_q;

	// ------------------------------------------------------------------------
	// opcode decode
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		write_enable <= 1'b0;
		sync         <= 1'b0;

		if (reset) begin
			n_active_blocks <= '0;
		end else if (cmd_valid) begin
			case (cmd_op)
				cmd_pkg::OP_SET_GAIN,
				cmd_pkg::OP_SET_OFFSET: write_enable <= 1'b1;
				cmd_pkg::OP_SET_ACTIVE: begin
					if (cmd_data >= block_pkg::N_BLOCKS)
						n_active_blocks <= block_pkg::block_addr_t'(block_pkg::N_BLOCKS - 1);
					else
						n_active_blocks <= cmd_data[7:0];
				end
				cmd_pkg::OP_SYNC:       sync <= 1'b1;
				default:                ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			write_select <= (cmd_op == cmd_pkg::OP_SET_OFFSET);  // 1 = high half
			write_addr   <= cmd_addr;
			write_value  <= cmd_data;
		end
	end

	// end of sync, one cycle after the fall
	always_ff @(posedge clk) begin
		if (reset) begin
			syncing_q <= 1'b0;
			sync_done <= 1'b0;
		end else begin
			syncing_q <= syncing;
			sync_done <= syncing_q & ~syncing;
		end
	end

endmodule

`default_nettype wire

// File: logic/block_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module block_regfile (
	input  wire logic                   clk,
	input  wire logic                   reset,

	input  wire block_pkg::block_addr_t n_active_blocks,

	input  wire block_pkg::block_addr_t read_addr,
	output logic                        read_valid,

	input  wire block_pkg::block_addr_t write_addr,
	input  wire block_pkg::data_t       write_value,
	input  wire logic                   write_select,
	input  wire logic                   write_enable,

	output block_pkg::data_t            register_0_out,
	output block_pkg::data_t            register_1_out,

	input  wire logic                   sync,
	input  wire block_pkg::block_addr_t sync_addr,
	input  wire block_pkg::word_t       sync_value,
	output logic                        syncing
);

	block_pkg::word_t       registers [block_pkg::N_BLOCKS];
	block_pkg::word_t       registers_packed_out;

	block_pkg::block_addr_t read_addr_int;
	block_pkg::block_addr_t write_addr_int;
	block_pkg::word_t       write_val_int;
	logic                   write_enable_int;

	logic                   write_issued;
	logic                   write_select_latched;
	block_pkg::data_t       write_val_latched;

	logic                   sync_start;
	block_pkg::block_addr_t sync_start_addr;
	block_pkg::block_addr_t sync_addr_prev;
	logic                   sync_addr_changed;
	logic                   sync_addr_changed_ever;
	logic                   sync_addr_wrapped;

	assign sync_start    = ~syncing & sync & (|n_active_blocks);
	assign read_addr_int = write_enable ? write_addr : read_addr;  // merge needs the old word

	// low while any write is pending so the sweeper never sees a stale word
	assign read_valid = ~(syncing | sync_start | write_enable | write_issued | write_enable_int);

	assign register_0_out = registers_packed_out[15:0];   // gain
	assign register_1_out = registers_packed_out[31:16];  // offset

	// ------------------------------------------------------------------------
	// block ram, registered read
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		registers_packed_out <= registers[read_addr_int];
		if (write_enable_int)
			registers[write_addr_int] <= write_val_int;
	end

	// ------------------------------------------------------------------------
	// half-word rmw and bulk sync
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		write_enable_int <= 1'b0;
		write_issued     <= 1'b0;

		if (reset) begin
			syncing           <= 1'b0;
			sync_addr_changed <= 1'b0;
		end else if (syncing) begin
			sync_addr_prev         <= sync_addr;
			sync_addr_changed      <= (sync_addr != sync_addr_prev);
			sync_addr_changed_ever <= sync_addr_changed_ever | sync_addr_changed;
			if (sync_addr_changed_ever && sync_addr == sync_start_addr)
				sync_addr_wrapped <= 1'b1;  // lap complete

			write_addr_int   <= sync_addr;
			write_val_int    <= sync_value;
			write_enable_int <= sync_addr_changed || (n_active_blocks < 8'd2);

			syncing <= ~((n_active_blocks == 8'd1) | sync_addr_wrapped);
		end else if (sync_start) begin
			syncing                <= 1'b1;
			sync_start_addr        <= sync_addr;
			sync_addr_prev         <= sync_addr;
			write_addr_int         <= sync_addr;
			write_val_int          <= sync_value;
			sync_addr_changed      <= 1'b0;
			sync_addr_changed_ever <= 1'b0;
			sync_addr_wrapped      <= 1'b0;
		end else begin
			if (write_enable) begin
				write_issued         <= 1'b1;
				write_select_latched <= write_select;
				write_val_latched    <= write_value;
				write_addr_int       <= write_addr;
			end

			if (write_issued) begin
				// old word is on the read port now
				if (write_select_latched)
					write_val_int <= {write_val_latched, register_0_out};
				else
					write_val_int <= {register_1_out, write_val_latched};
				write_enable_int <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/block_sweep.sv
`timescale 1ns/1ns
`default_nettype none

module block_sweep (
	input  wire logic                   clk,
	input  wire logic                   reset,

	input  wire logic                   sample_valid,
	input  wire block_pkg::block_addr_t sample_block,
	input  wire block_pkg::data_t       sample_value,
	output logic                        sample_busy,

	input  wire block_pkg::block_addr_t n_active_blocks,

	output block_pkg::block_addr_t      read_addr,
	input  wire logic                   read_valid,
	input  wire block_pkg::data_t       register_0_out,
	input  wire block_pkg::data_t       register_1_out,

	output logic                        raw_valid,
	output block_pkg::block_addr_t      raw_block,
	output block_pkg::acc_t             raw_sum
);

	typedef enum logic {
		SW_IDLE,
		SW_WAIT
	} sweep_state_t;

	sweep_state_t           state;
	block_pkg::block_addr_t block_q;
	block_pkg::data_t       value_q;
	logic                   fetch_valid;  // read_valid in the fetch cycle

	logic signed [31:0]     product;
	logic signed [33:0]     scaled;
	logic signed [33:0]     offset_ext;
	logic signed [33:0]     passthru;

	assign sample_busy = (state == SW_WAIT);
	assign read_addr   = (state == SW_IDLE) ? sample_block : block_q;  // fetch on accept

	assign product    = $signed(value_q) * $signed(register_0_out);
	assign scaled     = product >>> block_pkg::GAIN_SHIFT;
	assign offset_ext = $signed(register_1_out);
	assign passthru   = $signed(value_q);

	always_ff @(posedge clk) begin
		raw_valid <= 1'b0;

		if (reset) begin
			state       <= SW_IDLE;
			fetch_valid <= 1'b0;
		end else begin
			case (state)
				SW_IDLE: begin
					if (sample_valid) begin
						block_q     <= sample_block;
						value_q     <= sample_value;
						fetch_valid <= read_valid;
						state       <= SW_WAIT;
					end
				end
				SW_WAIT: begin
					if (fetch_valid && read_valid) begin
						raw_valid <= 1'b1;
						raw_block <= block_q;
						if (block_q < n_active_blocks)
							raw_sum <= scaled + offset_ext;
						else
							raw_sum <= passthru;
						state <= SW_IDLE;
					end else begin
						fetch_valid <= read_valid;  // address still held, retry
					end
				end
				default: state <= SW_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage (
	input  wire logic                   clk,
	input  wire logic                   reset,

	input  wire logic                   raw_valid,
	input  wire block_pkg::block_addr_t raw_block,
	input  wire block_pkg::acc_t        raw_sum,

	output logic                        result_valid,
	output block_pkg::block_addr_t      result_block,
	output block_pkg::data_t            result_value
);

	logic             fits;
	block_pkg::data_t clamped;

	// in range when the bits above the 16-bit sign all match it
	assign fits    = (&raw_sum[33:15]) | ~(|raw_sum[33:15]);
	assign clamped = {raw_sum[33], {15{~raw_sum[33]}}};  // 8000 or 7fff

	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= raw_valid;
	end

	always_ff @(posedge clk) begin
		if (raw_valid) begin
			result_block <= raw_block;
			result_value <= fits ? raw_sum[15:0] : clamped;
		end
	end

endmodule

`default_nettype wire

// File: logic/block_engine.sv
`timescale 1ns/1ns
`default_nettype none

module block_engine (
	input  wire logic                   clk,
	input  wire logic                   reset,

	input  wire logic                   cmd_valid,
	input  wire cmd_pkg::cmd_op_t       cmd_op,
	input  wire block_pkg::block_addr_t cmd_addr,
	input  wire block_pkg::data_t       cmd_data,

	input  wire block_pkg::block_addr_t sync_addr,
	input  wire block_pkg::word_t       sync_value,

	input  wire logic                   sample_valid,
	input  wire block_pkg::block_addr_t sample_block,
	input  wire block_pkg::data_t       sample_value,
	output logic                        sample_busy,

	output logic                        result_valid,
	output block_pkg::block_addr_t      result_block,
	output block_pkg::data_t            result_value,

	output logic                        syncing,
	output logic                        sync_done
);

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------
	logic                   write_enable;
	logic                   write_select;
	block_pkg::block_addr_t write_addr;
	block_pkg::data_t       write_value;
	logic                   sync;
	block_pkg::block_addr_t n_active_blocks;

	block_pkg::block_addr_t read_addr;
	logic                   read_valid;
	block_pkg::data_t       register_0_out;
	block_pkg::data_t       register_1_out;

	logic                   raw_valid;
	block_pkg::block_addr_t raw_block;
	block_pkg::acc_t        raw_sum;

	cmd_decode u_decode (
		.clk            (clk),
		.reset          (reset),
		.cmd_valid      (cmd_valid),
		.cmd_op         (cmd_op),
		.cmd_addr       (cmd_addr),
		.cmd_data       (cmd_data),
		.syncing        (syncing),
		.write_enable   (write_enable),
		.write_select   (write_select),
		.write_addr     (write_addr),
		.write_value    (write_value),
		.sync           (sync),
		.n_active_blocks(n_active_blocks),
		.sync_done      (sync_done)
	);

	block_regfile u_regfile (
		.clk            (clk),
		.reset          (reset),
		.n_active_blocks(n_active_blocks),
		.read_addr      (read_addr),
		.read_valid     (read_valid),
		.write_addr     (write_addr),
		.write_value    (write_value),
		.write_select   (write_select),
		.write_enable   (write_enable),
		.register_0_out (register_0_out),
		.register_1_out (register_1_out),
		.sync           (sync),
		.sync_addr      (sync_addr),
		.sync_value     (sync_value),
		.syncing        (syncing)
	);

	block_sweep u_sweep (
		.clk            (clk),
		.reset          (reset),
		.sample_valid   (sample_valid),
		.sample_block   (sample_block),
		.sample_value   (sample_value),
		.sample_busy    (sample_busy),
		.n_active_blocks(n_active_blocks),
		.read_addr      (read_addr),
		.read_valid     (read_valid),
		.register_0_out (register_0_out),
		.register_1_out (register_1_out),
		.raw_valid      (raw_valid),
		.raw_block      (raw_block),
		.raw_sum        (raw_sum)
	);

	result_stage u_result (
		.clk         (clk),
		.reset       (reset),
		.raw_valid   (raw_valid),
		.raw_block   (raw_block),
		.raw_sum     (raw_sum),
		.result_valid(result_valid),
		.result_block(result_block),
		.result_value(result_value)
	);

endmodule

`default_nettype wire

// File: tests/block_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

module block_engine_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int WAIT_LIMIT   = 100;
	localparam int RESULT_LIMIT = 50;
	localparam int SYNC_LIMIT   = 400;

	logic                   clk;
	logic                   reset;
	logic                   cmd_valid;
	cmd_pkg::cmd_op_t       cmd_op;
	block_pkg::block_addr_t cmd_addr;
	block_pkg::data_t       cmd_data;
	block_pkg::block_addr_t sync_addr;
	block_pkg::word_t       sync_value;
	logic                   sample_valid;
	block_pkg::block_addr_t sample_block;
	block_pkg::data_t       sample_value;
	logic                   sample_busy;
	logic                   result_valid;
	block_pkg::block_addr_t result_block;
	block_pkg::data_t       result_value;
	logic                   syncing;
	logic                   sync_done;

	block_pkg::word_t       shadow [block_pkg::N_BLOCKS];  // expected register words
	int                     model_active;
	block_pkg::block_addr_t exp_block [$];
	block_pkg::data_t       exp_value [$];
	integer                 seed;
	int                     errors;
	int                     timeouts;
	int                     checks;

	block_engine uut (
		.clk         (clk),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_addr    (cmd_addr),
		.cmd_data    (cmd_data),
		.sync_addr   (sync_addr),
		.sync_value  (sync_value),
		.sample_valid(sample_valid),
		.sample_block(sample_block),
		.sample_value(sample_value),
		.sample_busy (sample_busy),
		.result_valid(result_valid),
		.result_block(result_block),
		.result_value(result_value),
		.syncing     (syncing),
		.sync_done   (sync_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic block_pkg::data_t model_result(input int blk, input block_pkg::data_t smp);
		int     gain_i;
		int     offset_i;
		int     prod;
		longint sum;
		if (blk >= model_active)
			return smp;  // inactive block
		gain_i   = $signed(shadow[blk][15:0]);
		offset_i = $signed(shadow[blk][31:16]);
		prod     = $signed(smp) * gain_i;
		sum      = longint'(prod >>> block_pkg::GAIN_SHIFT) + offset_i;
		if (sum > 32767)
			return 16'h7fff;
		if (sum < -32768)
			return 16'h8000;
		return sum[15:0];
	endfunction

	task automatic next_drive_point;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic start_cmd(input cmd_pkg::cmd_op_t op, input int addr, input int data);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_addr  = addr[7:0];
		cmd_data  = data[15:0];
		case (op)
			cmd_pkg::OP_SET_GAIN:   shadow[addr][15:0]  = data[15:0];
			cmd_pkg::OP_SET_OFFSET: shadow[addr][31:16] = data[15:0];
			cmd_pkg::OP_SET_ACTIVE: model_active = data;
			default:                ;
		endcase
	endtask

	task automatic pulse_cmd(input cmd_pkg::cmd_op_t op, input int addr, input int data);
		start_cmd(op, addr, data);
		next_drive_point();
		cmd_valid = 1'b0;
	endtask

	task automatic issue_cmd(input cmd_pkg::cmd_op_t op, input int addr, input int data);
		pulse_cmd(op, addr, data);
		repeat (3) next_drive_point();  // command spacing, write done
	endtask

	task automatic send_sample(input int blk, input int value);
		int n;
		n = 0;
		while (sample_busy && n < WAIT_LIMIT) begin
			next_drive_point();
			n++;
		end
		if (sample_busy) begin
			timeouts++;
			$display("sample_busy stayed high for %0d cycles at %0t", WAIT_LIMIT, $time);
		end
		sample_valid = 1'b1;
		sample_block = blk[7:0];
		sample_value = value[15:0];
		exp_block.push_back(blk[7:0]);
		exp_value.push_back(model_result(blk, value[15:0]));
		next_drive_point();
		sample_valid = 1'b0;
		assert (sample_busy) else begin
			errors++;
			$display("sample_busy did not rise after a sample was accepted at %0t", $time);
		end
	endtask

	task automatic drain_results;
		int n;
		n = 0;
		while ((exp_block.size() != 0 || sample_busy) && n < WAIT_LIMIT) begin
			next_drive_point();
			n++;
		end
		if (exp_block.size() != 0) begin
			timeouts++;
			$display("%0d results still missing at %0t", exp_block.size(), $time);
		end
	endtask

	// external sweep source: one lap over the active blocks
	task automatic run_sync;
		int   idx;
		int   hold;
		int   n;
		int   limit;
		logic saw_syncing;
		logic saw_done;
		saw_syncing = 1'b0;
		saw_done    = 1'b0;
		limit       = (model_active == 0) ? 20 : SYNC_LIMIT;
		idx         = 0;
		if (model_active > 1)
			idx = {$random(seed)} % model_active;
		for (int b = 0; b < model_active; b++)
			shadow[b] = $random(seed);
		sync_addr  = idx[7:0];
		sync_value = shadow[idx];
		pulse_cmd(cmd_pkg::OP_SYNC, 0, 0);
		hold = 4;
		n    = 0;
		while (!saw_done && n < limit) begin
			next_drive_point();
			n++;
			if (syncing)
				saw_syncing = 1'b1;
			if (sync_done)
				saw_done = 1'b1;
			hold--;
			if (hold == 0 && model_active > 1) begin
				idx        = (idx + 1) % model_active;
				sync_addr  = idx[7:0];
				sync_value = shadow[idx];
				hold       = 2 + ({$random(seed)} % 2);  // 2 or 3 cycles
			end
		end
		if (model_active == 0) begin
			assert (!saw_syncing && !saw_done) else begin
				errors++;
				$display("sync started with no active blocks at %0t", $time);
			end
		end else begin
			assert (saw_syncing) else begin
				errors++;
				$display("syncing never went high at %0t", $time);
			end
			assert (saw_done) else begin
				timeouts++;
				$display("sync_done did not pulse within %0d cycles", limit);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// scoreboard
	// ------------------------------------------------------------------------
	initial begin
		int                     idle;
		block_pkg::block_addr_t want_block;
		block_pkg::data_t       want_value;
		idle = 0;
		forever begin
			@(negedge clk);
			if (result_valid) begin
				idle = 0;
				assert (exp_block.size() != 0) else begin
					errors++;
					$display("unexpected result for block %0d at %0t", result_block, $time);
				end
				if (exp_block.size() != 0) begin
					want_block = exp_block.pop_front();
					want_value = exp_value.pop_front();
					checks++;
					assert (result_block == want_block) else begin
						errors++;
						$display("mismatch at %0t: block %0d, expected %0d",
							$time, result_block, want_block);
					end
					assert (result_value === want_value) else begin
						errors++;
						$display("mismatch at %0t: block %0d value %h, expected %h",
							$time, want_block, result_value, want_value);
					end
				end
			end else if (exp_block.size() != 0) begin
				idle++;
				if (idle > RESULT_LIMIT) begin
					timeouts++;
					$display("no result for block %0d within %0d cycles", exp_block[0], RESULT_LIMIT);
					want_block = exp_block.pop_front();
					want_value = exp_value.pop_front();
					idle       = 0;
				end
			end
		end
	end

	initial begin
		seed         = 32'h0db0_3cf3;
		errors       = 0;
		timeouts     = 0;
		checks       = 0;
		model_active = 0;
		reset        = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = cmd_pkg::OP_SET_GAIN;
		cmd_addr     = '0;
		cmd_data     = '0;
		sync_addr    = '0;
		sync_value   = '0;
		sample_valid = 1'b0;
		sample_block = '0;
		sample_value = '0;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		next_drive_point();

		// half-word writes, then gain rewrites that must keep the offset
		issue_cmd(cmd_pkg::OP_SET_ACTIVE, 0, 8);
		for (int b = 0; b < 8; b++) begin
			issue_cmd(cmd_pkg::OP_SET_GAIN, b, $random(seed) % 512);
			issue_cmd(cmd_pkg::OP_SET_OFFSET, b, $random(seed) % 4096);
		end
		for (int b = 0; b < 8; b += 2)
			issue_cmd(cmd_pkg::OP_SET_GAIN, b, $random(seed) % 512);
		for (int b = 0; b < 8; b++)
			send_sample(b, $random(seed));
		drain_results();

		// saturation at both ends
		issue_cmd(cmd_pkg::OP_SET_GAIN, 1, 16'h7fff);
		issue_cmd(cmd_pkg::OP_SET_OFFSET, 1, 16'h7fff);
		issue_cmd(cmd_pkg::OP_SET_GAIN, 2, 16'h8000);
		issue_cmd(cmd_pkg::OP_SET_OFFSET, 2, 16'h8000);
		send_sample(1, 16'h7fff);
		send_sample(1, 16'h8000);
		send_sample(2, 16'h7fff);
		send_sample(2, 16'h8000);
		send_sample(2, 0);

		// inactive blocks pass through
		send_sample(8, $random(seed));
		send_sample(200, $random(seed));
		send_sample(255, $random(seed));
		drain_results();

		// sample strobed with a write command
		start_cmd(cmd_pkg::OP_SET_OFFSET, 3, $random(seed) % 4096);
		send_sample(3, $random(seed));
		cmd_valid = 1'b0;
		repeat (3) next_drive_point();
		drain_results();
		start_cmd(cmd_pkg::OP_SET_GAIN, 5, $random(seed) % 512);
		send_sample(5, $random(seed));
		cmd_valid = 1'b0;
		repeat (3) next_drive_point();
		drain_results();

		// bulk sync over 8 blocks
		run_sync();
		for (int b = 0; b < 10; b++)
			send_sample(b, $random(seed));
		drain_results();

		// single block, then none
		issue_cmd(cmd_pkg::OP_SET_ACTIVE, 0, 1);
		run_sync();
		send_sample(0, $random(seed));
		send_sample(1, $random(seed));
		drain_results();
		issue_cmd(cmd_pkg::OP_SET_ACTIVE, 0, 0);
		run_sync();
		send_sample(0, $random(seed));
		drain_results();

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/block_pkg.sv
logic/cmd_pkg.sv
logic/cmd_decode.sv
logic/block_regfile.sv
logic/block_sweep.sv
logic/result_stage.sv
logic/block_engine.sv
tests/block_engine_tb.sv
